/* common/icache_pkg.sv */
package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 64;
    localparam int TAG_W      = 23;
    localparam int INDEX_W    = 6;
    localparam int OFFSET_W   = 3;
    localparam int WORD_W     = 32;
    localparam int LINE_W     = 64;

    // fetch side
    typedef logic [31:0]         fetch_addr_t;
    typedef logic [WORD_W-1:0]   fetch_word_t;

    // address fields, tag is bits 31..9, index 8..3
    typedef logic [TAG_W-1:0]    cache_tag_t;
    typedef logic [INDEX_W-1:0]  set_index_t;
    typedef logic [OFFSET_W-1:0] line_offset_t;

    // one line per way
    typedef logic [LINE_W-1:0]   cache_line_t;

    // line-aligned address toward memory
    typedef logic [31:0]         mem_addr_t;

    // held fetch request, same bit layout as the byte address
    typedef struct packed {
        cache_tag_t   tag;
        set_index_t   index;
        line_offset_t offset;
    } fetch_req_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,
        MISS    = 2'd2,
        REPLACE = 2'd3
    } icache_state_e;

endpackage

/* source/fetch_req_buffer.sv */
`timescale 1ns/1ps

module fetch_req_buffer
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid,
    input  fetch_addr_t addr,
    input  logic        idle,
    output logic        accept,
    output fetch_req_t  req,
    output set_index_t  in_index
);

    fetch_req_t addr_split;

    // address viewed as tag / index / offset
    assign addr_split = fetch_req_t'(addr);

    // only one request in flight, so take it only while idle
    assign accept = valid & idle;

    // data store reads at the incoming index on the accept edge
    assign in_index = addr_split.index;

    // held through lookup and refill
    always_ff @(posedge clk) begin
        if (rst) begin
            req <= '0;
        end else if (accept) begin
            req <= addr_split;
        end
    end

endmodule

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       accept,
    input  logic [NUM_WAYS-1:0]        way_hit,
    input  cache_line_t [NUM_WAYS-1:0] way_lines,
    input  fetch_req_t                 req,
    output logic                       idle,
    output logic                       lookup,
    output logic                       miss,
    output logic                       replace,
    output logic                       data_ok,
    output fetch_word_t                rdata
);

    icache_state_e state;
    icache_state_e next_state;
    logic          cache_hit;
    fetch_word_t   way_word [NUM_WAYS];

    assign cache_hit = |way_hit;

    // state decodes
    assign idle    = (state == IDLE);
    assign lookup  = (state == LOOKUP);
    assign miss    = (state == MISS);
    assign replace = (state == REPLACE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                // a miss goes out to memory, a hit is done here
                if (cache_hit) begin
                    next_state = IDLE;
                end else begin
                    next_state = MISS;
                end
            end
            MISS: begin
                next_state = REPLACE;
            end
            REPLACE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // upper or lower word of each way by offset bit 2
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_word_sel
        assign way_word[w] = req.offset[2] ? way_lines[w][LINE_W-1:WORD_W]
                                           : way_lines[w][WORD_W-1:0];
    end

    // at most one way hits, so or-ing the masked words is enough
    always_comb begin
        rdata = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                rdata = rdata | way_word[w];
            end
        end
    end

    // way_hit is already zero outside lookup
    assign data_ok = lookup & cache_hit;

endmodule

/* icache/icache_tag_store.sv */
`timescale 1ns/1ps

module icache_tag_store
    import icache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                lookup,
    input  logic                replace,
    input  fetch_req_t          req,
    input  logic                victim_way,
    output logic [NUM_WAYS-1:0] way_hit
);

    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    cache_tag_t                        tag_mem [NUM_WAYS][NUM_SETS];

    // valid bits, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (replace) begin
            valid_q[victim_way][req.index] <= 1'b1;
        end
    end

    // tags written together with the valid bit
    always_ff @(posedge clk) begin
        if (replace) begin
            tag_mem[victim_way][req.index] <= req.tag;
        end
    end

    // compare on the held index, only while looking up
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_compare
        assign way_hit[w] = lookup
                          & valid_q[w][req.index]
                          & (tag_mem[w][req.index] == req.tag);
    end

endmodule

/* icache/icache_data_store.sv */
`timescale 1ns/1ps

module icache_data_store
    import icache_pkg::*;
(
    input  logic                       clk,
    input  logic                       accept,
    input  set_index_t                 in_index,
    input  logic                       replace,
    input  fetch_req_t                 req,
    input  logic                       victim_way,
    input  cache_line_t                refill_line,
    output cache_line_t [NUM_WAYS-1:0] way_lines
);

    // behavioral stand-in for the single-port line RAM
    cache_line_t line_mem [NUM_WAYS][NUM_SETS];

    // both ways read at the incoming index, data ready in LOOKUP
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                way_lines[w] <= line_mem[w][in_index];
            end
        end
    end

    // refill touches only the victim way
    always_ff @(posedge clk) begin
        if (replace) begin
            line_mem[victim_way][req.index] <= refill_line;
        end
    end

endmodule

/* source/refill_port.sv */
`timescale 1ns/1ps

module refill_port
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        miss,
    input  fetch_req_t  req,
    input  cache_line_t ret_data,
    output logic        rd_req,
    output mem_addr_t   rd_addr,
    output cache_line_t refill_line,
    output logic        victim_way
);

    logic way_toggle;

    // one read per miss, memory answers in the same cycle
    assign rd_req  = miss;
    assign rd_addr = {req.tag, req.index, {OFFSET_W{1'b0}}};

    // free-running pseudo-random way pick
    always_ff @(posedge clk) begin
        if (rst) begin
            way_toggle <= 1'b0;
        end else begin
            way_toggle <= ~way_toggle;
        end
    end

    // victim fixed at the refill, held through REPLACE
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_way <= 1'b0;
        end else if (rd_req) begin
            victim_way <= way_toggle;
        end
    end

    // miss line buffer
    always_ff @(posedge clk) begin
        if (rd_req) begin
            refill_line <= ret_data;
        end
    end

endmodule

/* source/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid,
    input  fetch_addr_t addr,
    output logic        addr_ok,
    output logic        data_ok,
    output fetch_word_t rdata,
    output logic        rd_req,
    output mem_addr_t   rd_addr,
    input  cache_line_t ret_data
);

    logic                       accept;
    fetch_req_t                 req;
    set_index_t                 in_index;
    logic                       idle;
    logic                       lookup;
    logic                       miss;
    logic                       replace;
    logic [NUM_WAYS-1:0]        way_hit;
    cache_line_t [NUM_WAYS-1:0] way_lines;
    cache_line_t                refill_line;
    logic                       victim_way;

    // address accepted whenever the controller is idle
    assign addr_ok = idle;

    fetch_req_buffer u_fetch_req_buffer (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .addr     (addr),
        .idle     (idle),
        .accept   (accept),
        .req      (req),
        .in_index (in_index)
    );

    icache_ctrl u_icache_ctrl (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .way_hit   (way_hit),
        .way_lines (way_lines),
        .req       (req),
        .idle      (idle),
        .lookup    (lookup),
        .miss      (miss),
        .replace   (replace),
        .data_ok   (data_ok),
        .rdata     (rdata)
    );

    icache_tag_store u_icache_tag_store (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup),
        .replace    (replace),
        .req        (req),
        .victim_way (victim_way),
        .way_hit    (way_hit)
    );

    icache_data_store u_icache_data_store (
        .clk         (clk),
        .accept      (accept),
        .in_index    (in_index),
        .replace     (replace),
        .req         (req),
        .victim_way  (victim_way),
        .refill_line (refill_line),
        .way_lines   (way_lines)
    );

    refill_port u_refill_port (
        .clk         (clk),
        .rst         (rst),
        .miss        (miss),
        .req         (req),
        .ret_data    (ret_data),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .refill_line (refill_line),
        .victim_way  (victim_way)
    );

endmodule

/* verif/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int RESET_CYCLES  = 10;
    localparam int WAIT_LIMIT    = 20;
    localparam int OBSERVE_LIMIT = 6;
    localparam int MISS_CYCLES   = 3;

    logic        clk;
    logic        rst;
    logic        valid;
    fetch_addr_t addr;
    logic        addr_ok;
    logic        data_ok;
    fetch_word_t rdata;
    logic        rd_req;
    mem_addr_t   rd_addr;
    cache_line_t ret_data;

    // misses among fetches whose way is not known in advance
    int group_misses;

    icache_top u_icache_top (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .addr     (addr),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // zero-wait memory, upper word first
    always_comb begin
        if (rd_req) begin
            ret_data = {rd_addr ^ 32'h5a5a0000, rd_addr ^ 32'h0000a5a5};
        end else begin
            ret_data = '0;
        end
    end

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_failure($sformatf("ERROR time=%0t %s expected=%h actual=%h",
                                  $time, sig, expected, actual));
    endtask

    // every action happens 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // no strobe may appear while nothing is in flight
    task automatic check_quiet_outputs();
        assert (data_ok == 1'b0) else report_mismatch("data_ok", 32'd0, 32'(data_ok));
        assert (rd_req == 1'b0) else report_mismatch("rd_req", 32'd0, 32'(rd_req));
    endtask

    task automatic apply_reset();
        rst   = 1'b1;
        valid = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            next_cycle();
            assert (addr_ok == 1'b1) else report_mismatch("addr_ok", 32'd1, 32'(addr_ok));
            check_quiet_outputs();
        end
        rst = 1'b0;
    endtask

    // one request, returns whether data_ok came and how many reads went out
    task automatic issue_fetch(input fetch_addr_t fetch_addr, output logic hit,
                               output fetch_word_t word, output int rd_count);
        int   n;
        logic done;
        hit      = 1'b0;
        word     = '0;
        rd_count = 0;
        n        = 0;
        done     = 1'b0;
        next_cycle();
        while (!done) begin
            check_quiet_outputs();
            if (addr_ok) begin
                done = 1'b1;
            end else if (n == WAIT_LIMIT) begin
                stop_on_failure("timeout: addr_ok stayed low before a new fetch");
            end else begin
                next_cycle();
                n++;
            end
        end
        valid = 1'b1;
        addr  = fetch_addr;
        next_cycle();
        valid = 1'b0;
        n     = 0;
        done  = 1'b0;
        while (!done) begin
            // reads are counted in every observed cycle, the last one too
            if (rd_req) begin
                rd_count++;
                assert (rd_addr == {fetch_addr[31:3], 3'b000})
                    else report_mismatch("rd_addr", {fetch_addr[31:3], 3'b000}, rd_addr);
            end
            if (data_ok) begin
                assert (n == 0)
                    else stop_on_failure("data_ok came later than the cycle after accept");
                hit  = 1'b1;
                word = rdata;
                done = 1'b1;
            end else if (addr_ok) begin
                assert (n == MISS_CYCLES)
                    else report_mismatch("miss busy cycles", MISS_CYCLES, n);
                done = 1'b1;
            end else if (n == OBSERVE_LIMIT - 1) begin
                stop_on_failure("timeout: neither data_ok nor addr_ok after a fetch");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // flag 1 must hit, flag 0 must miss first, flag 2 may do either
    task automatic run_fetch(input fetch_addr_t fetch_addr, input fetch_word_t exp_word,
                             input int flag);
        logic        hit;
        fetch_word_t word;
        int          rd_count;
        if (flag < 0 || flag > 2) begin
            stop_on_failure("data file holds a hit flag other than 0, 1 or 2");
        end
        issue_fetch(fetch_addr, hit, word, rd_count);
        if (flag == 1) begin
            assert (hit) else stop_on_failure($sformatf("fetch of %h missed, a hit was expected",
                                                        fetch_addr));
        end
        if (flag == 0) begin
            assert (!hit) else stop_on_failure($sformatf("fetch of %h hit, a miss was expected",
                                                         fetch_addr));
        end
        if (!hit) begin
            assert (rd_count == 1) else report_mismatch("rd_req pulses", 32'd1, rd_count);
            if (flag == 2) begin
                group_misses++;
            end
            // the fetch stage re-issues after a refill
            issue_fetch(fetch_addr, hit, word, rd_count);
            assert (hit) else stop_on_failure($sformatf("re-issued fetch of %h did not hit",
                                                        fetch_addr));
        end
        assert (rd_count == 0) else report_mismatch("rd_req pulses", 32'd0, rd_count);
        assert (word == exp_word) else report_mismatch("rdata", exp_word, word);
    endtask

    initial begin
        int                 fd;
        int                 code;
        int                 fetches;
        logic [7:0]         kind;
        fetch_addr_t        f_addr;
        fetch_word_t        f_word;
        int                 f_flag;
        int                 f_count;
        logic [8*256-1:0]   skip_line;
        rst          = 1'b1;
        valid        = 1'b0;
        addr         = '0;
        group_misses = 0;
        fetches      = 0;
        fd = $fopen("verif/icache_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_failure("could not open verif/icache_testdata.txt");
        end
        apply_reset();
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": begin
                    code = $fgets(skip_line, fd);
                end
                "F": begin
                    code = $fscanf(fd, "%h %h %d", f_addr, f_word, f_flag);
                    if (code != 3) begin
                        stop_on_failure("malformed fetch line in data file");
                    end
                    run_fetch(f_addr, f_word, f_flag);
                    fetches++;
                end
                "R": begin
                    apply_reset();
                end
                "C": begin
                    code = $fscanf(fd, "%d", f_count);
                    if (code != 1) begin
                        stop_on_failure("malformed miss count line in data file");
                    end
                    assert (group_misses == f_count)
                        else report_mismatch("eviction misses", f_count, group_misses);
                    group_misses = 0;
                end
                default: begin
                    stop_on_failure($sformatf("unknown line kind %c in data file", kind));
                end
            endcase
        end
        $fclose(fd);
        if (fetches == 0) begin
            stop_on_failure("data file held no fetch lines");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* icache_subsys.f */
common/icache_pkg.sv
source/fetch_req_buffer.sv
icache/icache_ctrl.sv
icache/icache_tag_store.sv
icache/icache_data_store.sv
source/refill_port.sv
source/icache_top.sv
verif/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
# the simulator exit status carries pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f icache_subsys.f \
    --top-module icache_tb \
    -o icache_sim \
    && ./obj_dir/icache_sim \
    || { echo "icache simulation did not complete cleanly"; exit 1; }

/* verif/icache_testdata.txt */
# F address expected_word hit_flag (1 hit, 0 cold miss, 2 either way, counted)
# R applies reset, C n expects n misses among flag 2 fetches since the last C
F 00001000 0000b5a5 0
F 00001004 5a5a1000 1
F 00001000 0000b5a5 1
F 00000128 0000a48d 0
F 0000012c 5a5a0128 1
F 00000128 0000a48d 1
# two tags in set 5
F 00010028 0001a58d 0
F 00020028 0002a58d 0
F 0001002c 5a5b0028 1
F 0002002c 5a580028 1
F 00010028 0001a58d 1
F 00020028 0002a58d 1
F 0001002c 5a5b0028 1
F 00001004 5a5a1000 1
# third tag into the full set
F 00030028 0003a58d 0
F 0002002c 5a580028 2
F 0001002c 5a5b0028 2
C 1
F 0003002c 5a590028 1
F 00010028 0001a58d 1
# valid bits cleared, old lines miss again
R
F 00001000 0000b5a5 0
F 00001004 5a5a1000 1
F 00030028 0003a58d 0
F 00010028 0001a58d 0
F 0003002c 5a590028 1
F 0001002c 5a5b0028 1
F 00020028 0002a58d 0
F 00010028 0001a58d 2
F 00030028 0003a58d 2
C 1
F 00000128 0000a48d 0
F 0000012c 5a5a0128 1
# top of the address space
F fffffe3c a5a5fe38 0
F fffffe38 ffff5b9d 1
F 0002002c 5a580028 1
